// ==== Makefile ====
# Verilator build and run of the engine testbench

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cgra_tb -f cgra.f -o cgra_sim
	@out="$$(./obj_dir/cgra_sim)"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== bench/cgra_tb.sv ====
/*
 directed testbench for the dataflow engine
   host bus access, port and unit configuration, run and done polling
   copy, vector ALU, multiply chain, shadow configuration and flow tests
   LFSR data source, value check and final report
*/

`timescale 1ns/10ps
`default_nettype none

module cgra_tb
   import cgra_pkg::*;
;

   localparam logic [31:0] LFSR_SEED  = 32'h705307ac;
   localparam logic [31:0] LFSR_TAPS  = 32'hb4bcd35c;
   localparam logic [7:0]  CTRL_ADDR  = 8'h40;
   localparam int          DONE_POLLS = 200;

   logic              rst;
   logic              clk;
   logic              valid;
   logic              we;
   logic [7:0]        addr;
   logic [DATA_W-1:0] wdata;
   logic [DATA_W-1:0] rdata;
   logic [DATA_W-1:0] flow_in;
   data_bus_t         flow_out;

   logic [31:0] lfsr_state;
   logic [31:0] mem_model [2][32];
   int          n_checks;
   int          n_errors;

   tb_clock #(
      .PERIOD_NS (8)
   ) i_tb_clock (
      .rst (rst)
   );

   cgra_top i_cgra_top (
      .rst      (rst),
      .clk      (clk),
      .valid    (valid),
      .we       (we),
      .addr     (addr),
      .wdata    (wdata),
      .rdata    (rdata),
      .flow_in  (flow_in),
      .flow_out (flow_out)
   );

   // galois LFSR stepped once per bit taken
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) begin
         lfsr_state = lfsr_state ^ LFSR_TAPS;
      end
      return b;
   endfunction

   function automatic logic [31:0] rand_word();
      logic [31:0] w;
      w = '0;
      for (int i = 0; i < 32; i++) begin
         w = {w[30:0], lfsr_bit()};
      end
      return w;
   endfunction

   function automatic logic [7:0] mem_addr(input int m, input int w);
      return {2'b00, m[0], w[4:0]};
   endfunction

   function automatic logic [7:0] conf_addr(input int k);
      return {5'b10000, k[2:0]};
   endfunction

   function automatic logic [31:0] port_word(input logic wr, input int start, input int incr,
                                             input int iter, input int delay,
                                             input logic [SEL_W-1:0] wsel);
      mem_port_conf_t p;
      p.en    = 1'b1;
      p.wr    = wr;
      p.start = start[MEM_ADDR_W-1:0];
      p.incr  = incr[MEM_ADDR_W-1:0];
      p.iter  = iter[ITER_W-1:0];
      p.delay = delay[DELAY_W-1:0];
      p.wsel  = wsel;
      return {{(32-$bits(p)){1'b0}}, p};
   endfunction

   function automatic logic [31:0] alu_word(input logic [ALU_OP_W-1:0] op,
                                            input logic [SEL_W-1:0] sa,
                                            input logic [SEL_W-1:0] sb);
      alu_conf_t c;
      c.op    = op;
      c.sel_a = sa;
      c.sel_b = sb;
      return {{(32-$bits(c)){1'b0}}, c};
   endfunction

   function automatic logic [31:0] mul_word(input logic [SEL_W-1:0] sa,
                                            input logic [SEL_W-1:0] sb);
      mul_conf_t c;
      c.sel_a = sa;
      c.sel_b = sb;
      return {{(32-$bits(c)){1'b0}}, c};
   endfunction

   // reference ALU with signed compare for max and min
   function automatic logic [31:0] alu_expect(input logic [ALU_OP_W-1:0] op,
                                              input logic [31:0] a, input logic [31:0] b);
      case (op)
         ALU_ADD:   return a + b;
         ALU_SUB:   return a - b;
         ALU_AND:   return a & b;
         ALU_OR:    return a | b;
         ALU_XOR:   return a ^ b;
         ALU_MAX:   return ($signed(a) > $signed(b)) ? a : b;
         ALU_MIN:   return ($signed(a) < $signed(b)) ? a : b;
         ALU_PASSA: return a;
         default:   return 32'h0;
      endcase
   endfunction

   function automatic logic [31:0] low_product(input logic [31:0] a, input logic [31:0] b);
      logic signed [63:0] p;
      p = $signed(a) * $signed(b);
      return p[31:0];
   endfunction

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("CHECK FAILED at %0t: %s, got %08h expected %08h", $time, what, got, exp);
      end
   endtask

   // all host tasks start and end on a falling edge
   task automatic host_write(input logic [7:0] a, input logic [31:0] d);
      valid = 1'b1;
      we    = 1'b1;
      addr  = a;
      wdata = d;
      @(negedge rst);
      valid = 1'b0;
      we    = 1'b0;
   endtask

   task automatic host_read(input logic [7:0] a, output logic [31:0] d);
      valid = 1'b1;
      we    = 1'b0;
      addr  = a;
      @(negedge rst);
      valid = 1'b0;
      d     = rdata;
   endtask

   task automatic configure_port(input int k, input logic wr, input int start, input int incr,
                                 input int iter, input int delay, input logic [SEL_W-1:0] wsel);
      host_write(conf_addr(k), port_word(wr, start, incr, iter, delay, wsel));
   endtask

   task automatic clear_conf();
      for (int k = 0; k < 7; k++) begin
         host_write(conf_addr(k), 32'h0);
      end
   endtask

   task automatic run_job();
      host_write(CTRL_ADDR, 32'h1);
   endtask

   task automatic wait_done();
      logic [31:0] status;
      int          polls;
      status = '0;
      polls  = 0;
      while (status[0] !== 1'b1 && polls < DONE_POLLS) begin
         host_read(CTRL_ADDR, status);
         polls++;
      end
      if (status[0] !== 1'b1) begin
         n_errors++;
         $display("engine did not report done within %0d status polls, at %0t",
                  DONE_POLLS, $time);
      end
   endtask

   task automatic fill_mem(input int m, input int first, input int count);
      logic [31:0] w;
      for (int i = 0; i < count; i++) begin
         w = rand_word();
         host_write(mem_addr(m, first + i), w);
         mem_model[m][(first + i) % 32] = w;
      end
   endtask

   task automatic end_test(input string name, input int err_start);
      $display("test %s finished with %0d errors", name, n_errors - err_start);
   endtask

   task automatic test_host_access();
      int          err_start;
      logic [31:0] d;
      logic [31:0] w;
      logic [31:0] mask;
      err_start = n_errors;
      host_read(CTRL_ADDR, d);
      check(d, 32'h1, "status after reset");
      fill_mem(0, 0, 32);
      fill_mem(1, 0, 32);
      for (int m = 0; m < 2; m++) begin
         for (int i = 0; i < 32; i++) begin
            host_read(mem_addr(m, i), d);
            check(d, mem_model[m][i], $sformatf("mem%0d[%0d] read-back", m, i));
         end
      end
      // unused conf bits and the empty address 7 read as zero
      for (int k = 0; k < 8; k++) begin
         w = rand_word();
         if (k < 4) begin
            mask = (32'h1 << $bits(mem_port_conf_t)) - 1;
         end else if (k < 6) begin
            mask = (32'h1 << $bits(alu_conf_t)) - 1;
         end else if (k == 6) begin
            mask = (32'h1 << $bits(mul_conf_t)) - 1;
         end else begin
            mask = 32'h0;
         end
         host_write(conf_addr(k), w);
         host_read(conf_addr(k), d);
         check(d, w & mask, $sformatf("conf reg %0d read-back", k));
      end
      clear_conf();
      end_test("host_access", err_start);
   endtask

   task automatic test_copy();
      int          err_start;
      logic [31:0] d;
      logic [4:0]  src;
      logic [4:0]  dst;
      err_start = n_errors;
      clear_conf();
      configure_port(0, 1'b0, 3, 2, 8, 0, SRC_MEM0A);
      configure_port(2, 1'b1, 30, -3, 8, 1, SRC_MEM0A);
      run_job();
      wait_done();
      for (int k = 0; k < 8; k++) begin
         src = 5'(3 + 2*k);
         dst = 5'(30 - 3*k);
         host_read(mem_addr(1, dst), d);
         check(d, mem_model[0][src], $sformatf("copy element %0d at mem1[%0d]", k, dst));
         mem_model[1][dst] = mem_model[0][src];
      end
      end_test("copy", err_start);
   endtask

   task automatic test_vector_alu();
      int                  err_start;
      logic [31:0]         d;
      logic [ALU_OP_W-1:0] opc;
      err_start = n_errors;
      fill_mem(0, 0, 16);
      clear_conf();
      configure_port(0, 1'b0, 0, 1, 8, 0, SRC_MEM0A);
      configure_port(1, 1'b0, 8, 1, 8, 0, SRC_MEM0A);
      // ALU result trails the read by one cycle
      configure_port(3, 1'b1, 8, 1, 8, 2, SRC_ALU0);
      for (int op = 0; op < 8; op++) begin
         opc = op[ALU_OP_W-1:0];
         host_write(conf_addr(4), alu_word(opc, SRC_MEM0A, SRC_MEM0B));
         run_job();
         wait_done();
         for (int k = 0; k < 8; k++) begin
            host_read(mem_addr(1, 8 + k), d);
            check(d, alu_expect(opc, mem_model[0][k], mem_model[0][8 + k]),
                  $sformatf("alu op %0d element %0d", op, k));
         end
      end
      end_test("vector_alu", err_start);
   endtask

   task automatic test_mul_chain();
      int          err_start;
      logic [31:0] d;
      logic [31:0] exp;
      err_start = n_errors;
      fill_mem(0, 0, 16);
      fill_mem(1, 0, 8);
      clear_conf();
      configure_port(0, 1'b0, 0, 1, 8, 0, SRC_MEM0A);
      configure_port(1, 1'b0, 8, 1, 8, 0, SRC_MEM0A);
      // third stream one cycle late to meet the product
      configure_port(2, 1'b0, 0, 1, 8, 1, SRC_MEM0A);
      configure_port(3, 1'b1, 16, 1, 8, 3, SRC_ALU1);
      host_write(conf_addr(5), alu_word(ALU_SUB, SRC_MUL0, SRC_MEM1A));
      host_write(conf_addr(6), mul_word(SRC_MEM0A, SRC_MEM0B));
      run_job();
      wait_done();
      for (int k = 0; k < 8; k++) begin
         exp = low_product(mem_model[0][k], mem_model[0][8 + k]) - mem_model[1][k];
         host_read(mem_addr(1, 16 + k), d);
         check(d, exp, $sformatf("mul chain element %0d", k));
      end
      end_test("mul_chain", err_start);
   endtask

   task automatic test_shadow_flow();
      int          err_start;
      logic [31:0] d;
      logic [31:0] flow_val;
      err_start = n_errors;
      fill_mem(0, 0, 16);
      fill_mem(1, 20, 4);
      clear_conf();
      configure_port(0, 1'b0, 0, 1, 4, 0, SRC_MEM0A);
      configure_port(1, 1'b0, 8, 1, 4, 0, SRC_MEM0A);
      configure_port(2, 1'b1, 4, 1, 4, 0, SRC_FLOW);
      host_write(conf_addr(4), alu_word(ALU_ADD, SRC_MEM0A, SRC_MEM0B));
      host_write(conf_addr(5), alu_word(ALU_XOR, SRC_MEM0A, SRC_MEM0B));
      flow_val = rand_word();
      flow_in  = flow_val;
      run_job();
      // must not reach the job already running
      configure_port(2, 1'b1, 20, 1, 4, 0, SRC_ALU0);
      wait_done();
      // ALU output settles one cycle after the last read
      repeat (2) @(negedge rst);
      check(flow_out.mem0a, mem_model[0][3], "mem0a word held after job");
      check(flow_out.mem0b, mem_model[0][11], "mem0b word held after job");
      check(flow_out.alu0, mem_model[0][3] + mem_model[0][11], "alu0 word held after job");
      check(flow_out.alu1, mem_model[0][3] ^ mem_model[0][11], "alu1 word held after job");
      check(flow_out.flow, flow_val, "flow word on the bus");
      for (int k = 0; k < 4; k++) begin
         host_read(mem_addr(1, 4 + k), d);
         check(d, flow_val, $sformatf("flow stored at mem1[%0d]", 4 + k));
         host_read(mem_addr(1, 20 + k), d);
         check(d, mem_model[1][20 + k], $sformatf("mem1[%0d] untouched", 20 + k));
      end
      flow_in = '0;
      clear_conf();
      end_test("shadow_flow", err_start);
   endtask

   initial begin
      valid      = 1'b0;
      we         = 1'b0;
      addr       = '0;
      wdata      = '0;
      flow_in    = '0;
      clk        = 1'b1;
      lfsr_state = LFSR_SEED;
      n_checks   = 0;
      n_errors   = 0;
      repeat (8) @(negedge rst);
      clk = 1'b0;
      @(negedge rst);
      test_host_access();
      test_copy();
      test_vector_alu();
      test_mul_chain();
      test_shadow_flow();
      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
/*
 testbench clock source
   free-running clock, 8 ns period
*/

`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD_NS = 8
) (
   output logic rst
);

   // rst is the clock net of this design
   initial begin
      rst = 1'b0;
   end

   always #(PERIOD_NS/2) rst = ~rst;

endmodule

`default_nettype wire

// ==== cgra.f ====
hdl/cgra_pkg.sv
hdl/conf_regs.sv
hdl/mem_unit.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/data_engine.sv
hdl/cgra_top.sv
bench/tb_clock.sv
bench/cgra_tb.sv

// ==== hdl/alu_unit.sv ====
/*
 two-operand ALU on the data bus
   operand select by source index
   signed add, sub, logic ops, max, min and pass
   registered output, cleared on run
*/

`timescale 1ns/10ps
`default_nettype none

module alu_unit
   import cgra_pkg::*;
(
   input  wire logic         rst,
   input  wire logic         clk,
   input  wire logic         run,
   input  wire data_bus_t    bus,
   input  wire alu_conf_t    conf,
   output logic [DATA_W-1:0] out
);

   logic signed [DATA_W-1:0] op_a;
   logic signed [DATA_W-1:0] op_b;
   logic signed [DATA_W-1:0] result;

   assign op_a = bus_word(bus, conf.sel_a);
   assign op_b = bus_word(bus, conf.sel_b);

   always_comb begin
      case (conf.op)
         ALU_ADD:   result = op_a + op_b;
         ALU_SUB:   result = op_a - op_b;
         ALU_AND:   result = op_a & op_b;
         ALU_OR:    result = op_a | op_b;
         ALU_XOR:   result = op_a ^ op_b;
         ALU_MAX:   result = (op_a > op_b) ? op_a : op_b;
         ALU_MIN:   result = (op_a < op_b) ? op_a : op_b;
         ALU_PASSA: result = op_a;
         default:   result = '0;
      endcase
   end

   // a new job starts from a clean output
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         out <= '0;
      end else if (run) begin
         out <= '0;
      end else begin
         out <= result;
      end
   end

   // the shadow configuration must carry a defined opcode into every job
   a_op_in_range: assert property (@(posedge rst) disable iff (clk)
      run |-> conf.op <= ALU_PASSA)
      else $error("alu_unit: opcode %0d out of range at run", conf.op);

endmodule

`default_nettype wire

// ==== hdl/cgra_pkg.sv ====
/*
 shared definitions for the dataflow engine
   datapath and memory widths, unit counts
   data bus source indices and ALU opcodes
   data bus, port, ALU, MUL and engine configuration structs
   data bus word select function
*/

`default_nettype none

package cgra_pkg;

   localparam int DATA_W     = 32;
   localparam int MEM_ADDR_W = 5;
   localparam int N_MEM      = 2;
   localparam int N_ALU      = 2;
   localparam int N_SRC      = 8;
   localparam int SEL_W      = 3;
   localparam int ITER_W     = 6;
   localparam int DELAY_W    = 5;
   localparam int ALU_OP_W   = 4;

   // data bus sources in bus order
   localparam logic [SEL_W-1:0] SRC_MEM0A = 3'd0;
   localparam logic [SEL_W-1:0] SRC_MEM0B = 3'd1;
   localparam logic [SEL_W-1:0] SRC_MEM1A = 3'd2;
   localparam logic [SEL_W-1:0] SRC_MEM1B = 3'd3;
   localparam logic [SEL_W-1:0] SRC_ALU0  = 3'd4;
   localparam logic [SEL_W-1:0] SRC_ALU1  = 3'd5;
   localparam logic [SEL_W-1:0] SRC_MUL0  = 3'd6;
   localparam logic [SEL_W-1:0] SRC_FLOW  = 3'd7;

   localparam logic [ALU_OP_W-1:0] ALU_ADD   = 4'd0;
   localparam logic [ALU_OP_W-1:0] ALU_SUB   = 4'd1;
   localparam logic [ALU_OP_W-1:0] ALU_AND   = 4'd2;
   localparam logic [ALU_OP_W-1:0] ALU_OR    = 4'd3;
   localparam logic [ALU_OP_W-1:0] ALU_XOR   = 4'd4;
   localparam logic [ALU_OP_W-1:0] ALU_MAX   = 4'd5;
   localparam logic [ALU_OP_W-1:0] ALU_MIN   = 4'd6;
   localparam logic [ALU_OP_W-1:0] ALU_PASSA = 4'd7;

   // first field sits in the top word
   typedef struct packed {
      logic [DATA_W-1:0] mem0a;
      logic [DATA_W-1:0] mem0b;
      logic [DATA_W-1:0] mem1a;
      logic [DATA_W-1:0] mem1b;
      logic [DATA_W-1:0] alu0;
      logic [DATA_W-1:0] alu1;
      logic [DATA_W-1:0] mul0;
      logic [DATA_W-1:0] flow;
   } data_bus_t;

   typedef struct packed {
      logic                         en;
      logic                         wr;
      logic [MEM_ADDR_W-1:0]        start;
      logic signed [MEM_ADDR_W-1:0] incr;
      logic [ITER_W-1:0]            iter;
      logic [DELAY_W-1:0]           delay;
      logic [SEL_W-1:0]             wsel;
   } mem_port_conf_t;

   typedef struct packed {
      logic [ALU_OP_W-1:0] op;
      logic [SEL_W-1:0]    sel_a;
      logic [SEL_W-1:0]    sel_b;
   } alu_conf_t;

   typedef struct packed {
      logic [SEL_W-1:0] sel_a;
      logic [SEL_W-1:0] sel_b;
   } mul_conf_t;

   // port 2*i is memory i side A, 2*i+1 side B
   typedef struct packed {
      mem_port_conf_t [2*N_MEM-1:0] port;
      alu_conf_t [N_ALU-1:0]        alu;
      mul_conf_t                    mul0;
   } engine_conf_t;

   function automatic logic [DATA_W-1:0] bus_word(data_bus_t b, logic [SEL_W-1:0] sel);
      logic [N_SRC-1:0][DATA_W-1:0] words;
      words = b;
      return words[N_SRC-1-int'(sel)];
   endfunction

endpackage

`default_nettype wire

// ==== hdl/cgra_top.sv ====
/*
 engine top level
   host address split between configuration registers and engine
   registered read-back select
*/

`timescale 1ns/10ps
`default_nettype none

module cgra_top
   import cgra_pkg::*;
#(
   parameter int HOST_ADDR_W = 8,
   parameter int CONF_ADDR_W = 3
) (
   input  wire logic                   rst,
   input  wire logic                   clk,
   input  wire logic                   valid,
   input  wire logic                   we,
   input  wire logic [HOST_ADDR_W-1:0] addr,
   input  wire logic [DATA_W-1:0]      wdata,
   output logic [DATA_W-1:0]           rdata,
   input  wire logic [DATA_W-1:0]      flow_in,
   output data_bus_t                   flow_out
);

   engine_conf_t      conf;
   logic              conf_valid;
   logic              eng_valid;
   logic              rsel_q;
   logic [DATA_W-1:0] conf_rdata;
   logic [DATA_W-1:0] eng_rdata;

   // upper half of the map is configuration
   assign conf_valid = valid && addr[HOST_ADDR_W-1];
   assign eng_valid  = valid && !addr[HOST_ADDR_W-1];

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         rsel_q <= 1'b0;
      end else if (valid) begin
         rsel_q <= addr[HOST_ADDR_W-1];
      end
   end

   assign rdata = rsel_q ? conf_rdata : eng_rdata;

   conf_regs #(
      .ADDR_W (CONF_ADDR_W)
   ) i_conf_regs (
      .rst   (rst),
      .clk   (clk),
      .valid (conf_valid),
      .we    (we),
      .addr  (addr[CONF_ADDR_W-1:0]),
      .wdata (wdata),
      .rdata (conf_rdata),
      .conf  (conf)
   );

   data_engine #(
      .ADDR_W (HOST_ADDR_W-1)
   ) i_data_engine (
      .rst      (rst),
      .clk      (clk),
      .valid    (eng_valid),
      .we       (we),
      .addr     (addr[HOST_ADDR_W-2:0]),
      .wdata    (wdata),
      .rdata    (eng_rdata),
      .flow_in  (flow_in),
      .flow_out (flow_out),
      .conf     (conf)
   );

endmodule

`default_nettype wire

// ==== hdl/conf_regs.sv ====
/*
 host configuration register file
   seven masked registers with registered read-back
   packing into the engine configuration struct
*/

`timescale 1ns/10ps
`default_nettype none

module conf_regs
   import cgra_pkg::*;
#(
   parameter int ADDR_W = 3
) (
   input  wire logic              rst,
   input  wire logic              clk,
   input  wire logic              valid,
   input  wire logic              we,
   input  wire logic [ADDR_W-1:0] addr,
   input  wire logic [DATA_W-1:0] wdata,
   output logic [DATA_W-1:0]      rdata,
   output engine_conf_t           conf
);

   localparam int N_REGS    = 2*N_MEM + N_ALU + 1;
   localparam int PORT_BITS = $bits(mem_port_conf_t);
   localparam int ALU_BITS  = $bits(alu_conf_t);
   localparam int MUL_BITS  = $bits(mul_conf_t);

   localparam logic [DATA_W-1:0] PORT_MASK = {{(DATA_W-PORT_BITS){1'b0}}, {PORT_BITS{1'b1}}};
   localparam logic [DATA_W-1:0] ALU_MASK  = {{(DATA_W-ALU_BITS){1'b0}}, {ALU_BITS{1'b1}}};
   localparam logic [DATA_W-1:0] MUL_MASK  = {{(DATA_W-MUL_BITS){1'b0}}, {MUL_BITS{1'b1}}};

   logic [DATA_W-1:0] regs [N_REGS];
   logic [DATA_W-1:0] wmask;

   // ports first, then ALUs, MUL last
   always_comb begin
      if (addr < 2*N_MEM) begin
         wmask = PORT_MASK;
      end else if (addr < 2*N_MEM + N_ALU) begin
         wmask = ALU_MASK;
      end else begin
         wmask = MUL_MASK;
      end
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         for (int k = 0; k < N_REGS; k++) begin
            regs[k] <= '0;
         end
      end else if (valid && we && addr < N_REGS) begin
         regs[addr] <= wdata & wmask;
      end
   end

   // address 7 has no register behind it
   always_ff @(posedge rst) begin
      if (valid) begin
         rdata <= (addr < N_REGS) ? regs[addr] : '0;
      end
   end

   always_comb begin
      for (int k = 0; k < 2*N_MEM; k++) begin
         conf.port[k] = mem_port_conf_t'(regs[k][PORT_BITS-1:0]);
      end
      for (int k = 0; k < N_ALU; k++) begin
         conf.alu[k] = alu_conf_t'(regs[2*N_MEM+k][ALU_BITS-1:0]);
      end
      conf.mul0 = mul_conf_t'(regs[N_REGS-1][MUL_BITS-1:0]);
   end

endmodule

`default_nettype wire

// ==== hdl/data_engine.sv ====
/*
 dataflow engine core
   host decode into memory strobes and control/status register
   run pulse, run_reg and configuration shadow register
   data bus assembly and done status
   memory, ALU and MUL unit instances
*/

`timescale 1ns/10ps
`default_nettype none

module data_engine
   import cgra_pkg::*;
#(
   parameter int ADDR_W = 7
) (
   input  wire logic              rst,
   input  wire logic              clk,
   input  wire logic              valid,
   input  wire logic              we,
   input  wire logic [ADDR_W-1:0] addr,
   input  wire logic [DATA_W-1:0] wdata,
   output logic [DATA_W-1:0]      rdata,
   input  wire logic [DATA_W-1:0] flow_in,
   output data_bus_t              flow_out,
   input  wire engine_conf_t      conf
);

   localparam int MSEL_W = $clog2(N_MEM);

   data_bus_t           bus;
   engine_conf_t        shadow;
   logic                ctrl_sel;
   logic [N_MEM-1:0]    mem_valid;
   logic                ctrl_q;
   logic [MSEL_W-1:0]   mem_q;
   logic                run;
   logic                run_reg;
   logic                done;
   logic [2*N_MEM-1:0]  port_done;
   logic [DATA_W-1:0]   port_out [2*N_MEM];
   logic [DATA_W-1:0]   mem_rdata [N_MEM];
   logic [DATA_W-1:0]   alu_out [N_ALU];
   logic [DATA_W-1:0]   mul_out;

   // top address bit picks control/status, the bits above a word pick the memory
   always_comb begin
      ctrl_sel  = addr[ADDR_W-1];
      mem_valid = '0;
      for (int j = 0; j < N_MEM; j++) begin
         if (!ctrl_sel && addr[MEM_ADDR_W +: MSEL_W] == MSEL_W'(j)) begin
            mem_valid[j] = valid;
         end
      end
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         ctrl_q <= 1'b0;
         mem_q  <= '0;
      end else if (valid) begin
         ctrl_q <= ctrl_sel;
         mem_q  <= addr[MEM_ADDR_W +: MSEL_W];
      end
   end

   assign done  = &port_done;
   assign rdata = ctrl_q ? {{(DATA_W-1){1'b0}}, done} : mem_rdata[mem_q];

   // writing 1 to the control register starts a job
   assign run = valid && we && ctrl_sel && wdata[0];

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         run_reg <= 1'b0;
         shadow  <= '0;
      end else begin
         run_reg <= run;
         if (run) begin
            shadow <= conf;
         end
      end
   end

   assign bus.mem0a = port_out[0];
   assign bus.mem0b = port_out[1];
   assign bus.mem1a = port_out[2];
   assign bus.mem1b = port_out[3];
   assign bus.alu0  = alu_out[0];
   assign bus.alu1  = alu_out[1];
   assign bus.mul0  = mul_out;
   assign bus.flow  = flow_in;
   assign flow_out  = bus;

   for (genvar i = 0; i < N_MEM; i++) begin : g_mem
      mem_unit i_mem_unit (
         .rst    (rst),
         .clk    (clk),
         .run    (run_reg),
         .valid  (mem_valid[i]),
         .we     (we),
         .addr   (addr[MEM_ADDR_W-1:0]),
         .wdata  (wdata),
         .rdata  (mem_rdata[i]),
         .bus    (bus),
         .conf_a (shadow.port[2*i]),
         .conf_b (shadow.port[2*i+1]),
         .out_a  (port_out[2*i]),
         .out_b  (port_out[2*i+1]),
         .done_a (port_done[2*i]),
         .done_b (port_done[2*i+1])
      );
   end

   for (genvar i = 0; i < N_ALU; i++) begin : g_alu
      alu_unit i_alu_unit (
         .rst  (rst),
         .clk  (clk),
         .run  (run_reg),
         .bus  (bus),
         .conf (shadow.alu[i]),
         .out  (alu_out[i])
      );
   end

   mul_unit i_mul_unit (
      .rst  (rst),
      .clk  (clk),
      .run  (run_reg),
      .bus  (bus),
      .conf (shadow.mul0),
      .out  (mul_out)
   );

   // the host shares memory port A with the running job
   a_no_host_while_busy: assert property (@(posedge rst) disable iff (clk)
      (|mem_valid) |-> done)
      else $error("data_engine: host memory access while the engine is busy");

endmodule

`default_nettype wire

// ==== hdl/mem_unit.sv ====
/*
 dual-port data memory unit
   two address generators with start delay and iteration count
   read onto the data bus or store a selected bus source
   host read and write through port A while idle
   per-port done flags
*/

`timescale 1ns/10ps
`default_nettype none

module mem_unit
   import cgra_pkg::*;
(
   input  wire logic                  rst,
   input  wire logic                  clk,
   input  wire logic                  run,
   input  wire logic                  valid,
   input  wire logic                  we,
   input  wire logic [MEM_ADDR_W-1:0] addr,
   input  wire logic [DATA_W-1:0]     wdata,
   output logic [DATA_W-1:0]          rdata,
   input  wire data_bus_t             bus,
   input  wire mem_port_conf_t        conf_a,
   input  wire mem_port_conf_t        conf_b,
   output logic [DATA_W-1:0]          out_a,
   output logic [DATA_W-1:0]          out_b,
   output logic                       done_a,
   output logic                       done_b
);

   logic [DATA_W-1:0]     mem [2**MEM_ADDR_W];
   mem_port_conf_t        cfg [2];
   logic                  fire [2];
   logic [MEM_ADDR_W-1:0] cur_addr [2];
   logic [DATA_W-1:0]     wr_data [2];
   logic [1:0]            done_v;
   logic [DATA_W-1:0]     q_a;
   logic [DATA_W-1:0]     q_b;

   assign cfg[0] = conf_a;
   assign cfg[1] = conf_b;

   for (genvar p = 0; p < 2; p++) begin : g_port
      logic [DELAY_W-1:0]    delay_cnt;
      logic [ITER_W-1:0]     iter_cnt;
      logic [MEM_ADDR_W-1:0] addr_acc;
      logic [DELAY_W-1:0]    eff_delay;
      logic [ITER_W-1:0]     eff_iter;

      // in the run cycle the port works straight from its configuration
      assign eff_delay   = run ? cfg[p].delay : delay_cnt;
      assign eff_iter    = run ? (cfg[p].en ? cfg[p].iter : '0) : iter_cnt;
      assign cur_addr[p] = run ? cfg[p].start : addr_acc;

      // one element per cycle once the delay has run out
      assign fire[p]    = (eff_iter != '0) && (eff_delay == '0);
      assign done_v[p]  = (eff_iter == '0);
      assign wr_data[p] = bus_word(bus, cfg[p].wsel);

      always_ff @(posedge rst or posedge clk) begin
         if (clk) begin
            delay_cnt <= '0;
            iter_cnt  <= '0;
            addr_acc  <= '0;
         end else begin
            delay_cnt <= (eff_delay != '0) ? eff_delay - 1'b1 : '0;
            iter_cnt  <= fire[p] ? eff_iter - 1'b1 : eff_iter;
            // two's complement incr wraps inside the memory
            addr_acc  <= fire[p] ? cur_addr[p] + cfg[p].incr : cur_addr[p];
         end
      end
   end

   // port A shares its write path with the host
   always_ff @(posedge rst) begin
      if (fire[0] && cfg[0].wr) begin
         mem[cur_addr[0]] <= wr_data[0];
      end else if (valid && we) begin
         mem[addr] <= wdata;
      end
      if (fire[1] && cfg[1].wr) begin
         mem[cur_addr[1]] <= wr_data[1];
      end
   end

   // read registers hold their word when the port is quiet
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         q_a <= '0;
         q_b <= '0;
      end else begin
         if (fire[0] && !cfg[0].wr) begin
            q_a <= mem[cur_addr[0]];
         end else if (valid && !we) begin
            q_a <= mem[addr];
         end
         if (fire[1] && !cfg[1].wr) begin
            q_b <= mem[cur_addr[1]];
         end
      end
   end

   assign out_a  = q_a;
   assign out_b  = q_b;
   assign rdata  = q_a;
   assign done_a = done_v[0];
   assign done_b = done_v[1];

   // both generators storing to one word would lose a result
   a_no_write_clash: assert property (@(posedge rst) disable iff (clk)
      !(fire[0] && cfg[0].wr && fire[1] && cfg[1].wr && cur_addr[0] == cur_addr[1]))
      else $error("mem_unit: ports A and B write word %0d in one cycle", cur_addr[0]);

endmodule

`default_nettype wire

// ==== hdl/mul_unit.sv ====
/*
 signed multiplier on the data bus
   operand select by source index
   registered low product word, cleared on run
*/

`timescale 1ns/10ps
`default_nettype none

module mul_unit
   import cgra_pkg::*;
(
   input  wire logic         rst,
   input  wire logic         clk,
   input  wire logic         run,
   input  wire data_bus_t    bus,
   input  wire mul_conf_t    conf,
   output logic [DATA_W-1:0] out
);

   logic signed [DATA_W-1:0]   op_a;
   logic signed [DATA_W-1:0]   op_b;
   logic signed [2*DATA_W-1:0] product;

   assign op_a    = bus_word(bus, conf.sel_a);
   assign op_b    = bus_word(bus, conf.sel_b);
   assign product = op_a * op_b;

   // only the low word goes back on the bus
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         out <= '0;
      end else if (run) begin
         out <= '0;
      end else begin
         out <= product[DATA_W-1:0];
      end
   end

endmodule

`default_nettype wire
